//--- common/tlb_macros.svh
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// TLB geometry

// log2 of the number of sets in each way
`define TLB_ENTRIES_W 4

// log2 of the number of ways
`define TLB_WAYS_W 2

`define TLB_WAYS (1 << `TLB_WAYS_W)

// commands from the arbiter to the TLB
`define TLB_CMD_NONE 2'd0
`define TLB_CMD_RESOLVE 2'd1
`define TLB_CMD_WRITE 2'd2
`define TLB_CMD_INVALIDATE 2'd3

// position of the valid flag inside the access tag
`define TLB_VALID_BIT 0

`endif

//--- common/tlb_pkg.sv
`default_nettype none

`include "tlb_macros.svh"

package tlb_pkg;

    // virtual page number
    // low TLB_ENTRIES_W bits pick the set, the upper bits form the vtag
    typedef logic [19:0] vpn_t;

    // physical page number
    typedef logic [21:0] ppn_t;

    // access tag where bit 0 marks a valid entry
    typedef logic [7:0] accesstag_t;

    // carries the TLB_CMD_* codes
    typedef logic [1:0] tlb_cmd_t;

    // set within one way
    typedef logic [`TLB_ENTRIES_W-1:0] set_index_t;

endpackage

`default_nettype wire

//--- common/arb_pkg.sv
`default_nettype none

package arb_pkg;

    // lookup client number
    typedef logic client_t;

    localparam client_t client_fetch = 1'b0;
    localparam client_t client_data = 1'b1;

    // who wins when both clients request together
    typedef enum logic {
        prefer_fetch,
        prefer_data
    } arb_state_t;

endpackage

`default_nettype wire

//--- tlb/mem_1w1r.sv
`default_nettype none

module mem_1w1r #(
    parameter int elements_w = 4,
    parameter int width = 8
) (
    input  logic                  clk,

    input  logic                  read,
    input  logic [elements_w-1:0] read_address,
    output logic [width-1:0]      read_data,

    input  logic                  write,
    input  logic [elements_w-1:0] write_address,
    input  logic [width-1:0]      write_data
);

    localparam int depth = 1 << elements_w;

    logic [width-1:0] storage [depth];

    always_ff @(posedge clk) begin
        if (write) begin
            storage[write_address] <= write_data;
        end
    end

    // read register holds its word until the next read
    // a colliding write is seen by the following read only
    always_ff @(posedge clk) begin
        if (read) begin
            read_data <= storage[read_address];
        end
    end

endmodule

`default_nettype wire

//--- tlb/tlb_way.sv
`default_nettype none

`include "tlb_macros.svh"

module tlb_way (
    input  logic                clk,
    input  logic                rst_n,

    input  tlb_pkg::tlb_cmd_t   command,

    // lookup side
    input  tlb_pkg::vpn_t       lookup_vaddr,
    output logic                hit,
    output tlb_pkg::ppn_t       phys,
    output tlb_pkg::accesstag_t accesstag,

    // write side
    input  tlb_pkg::vpn_t       wr_vaddr,
    input  tlb_pkg::ppn_t       wr_phys,
    input  tlb_pkg::accesstag_t wr_accesstag,

    // invalidate side
    input  tlb_pkg::set_index_t inv_index
);

    import tlb_pkg::*;

    localparam int vtag_w = $bits(vpn_t) - `TLB_ENTRIES_W;

    typedef logic [vtag_w-1:0] vtag_t;

    set_index_t lookup_set;
    set_index_t write_set;
    vtag_t      lookup_vtag;
    vtag_t      write_vtag;

    logic       resolve;
    logic       write_entry;
    logic       invalidate;

    // vtag of the lookup whose data sits in the read registers
    vtag_t      held_vtag;
    logic       resolved;

    vtag_t      stored_vtag;
    ppn_t       stored_ptag;
    accesstag_t stored_accesstag;

    set_index_t tag_write_set;
    accesstag_t tag_write_data;

    assign lookup_set  = lookup_vaddr[`TLB_ENTRIES_W-1:0];
    assign lookup_vtag = lookup_vaddr[$bits(vpn_t)-1:`TLB_ENTRIES_W];
    assign write_set   = wr_vaddr[`TLB_ENTRIES_W-1:0];
    assign write_vtag  = wr_vaddr[$bits(vpn_t)-1:`TLB_ENTRIES_W];

    assign resolve     = (command == `TLB_CMD_RESOLVE);
    assign write_entry = (command == `TLB_CMD_WRITE);
    assign invalidate  = (command == `TLB_CMD_INVALIDATE);

    // invalidate only zeroes the access tag
    assign tag_write_set  = invalidate ? inv_index : write_set;
    assign tag_write_data = invalidate ? '0 : wr_accesstag;

    mem_1w1r #(.elements_w(`TLB_ENTRIES_W), .width(vtag_w)) vtag_storage (
        .clk           (clk),
        .read          (resolve),
        .read_address  (lookup_set),
        .read_data     (stored_vtag),
        .write         (write_entry),
        .write_address (write_set),
        .write_data    (write_vtag)
    );

    mem_1w1r #(.elements_w(`TLB_ENTRIES_W), .width($bits(ppn_t))) ptag_storage (
        .clk           (clk),
        .read          (resolve),
        .read_address  (lookup_set),
        .read_data     (stored_ptag),
        .write         (write_entry),
        .write_address (write_set),
        .write_data    (wr_phys)
    );

    mem_1w1r #(.elements_w(`TLB_ENTRIES_W), .width($bits(accesstag_t))) accesstag_storage (
        .clk           (clk),
        .read          (resolve),
        .read_address  (lookup_set),
        .read_data     (stored_accesstag),
        .write         (write_entry || invalidate),
        .write_address (tag_write_set),
        .write_data    (tag_write_data)
    );

    always_ff @(posedge clk) begin
        if (resolve) begin
            held_vtag <= lookup_vtag;
        end
    end

    // no hit before the first lookup since reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resolved <= 1'b0;
        end else if (resolve) begin
            resolved <= 1'b1;
        end
    end

    assign hit       = resolved && stored_accesstag[`TLB_VALID_BIT]
                       && (held_vtag == stored_vtag);
    assign phys      = stored_ptag;
    assign accesstag = stored_accesstag;

endmodule

`default_nettype wire

//--- tlb/tlb.sv
`default_nettype none

`include "tlb_macros.svh"

module tlb (
    input  logic                clk,
    input  logic                rst_n,

    input  tlb_pkg::tlb_cmd_t   command,

    // lookup side
    input  tlb_pkg::vpn_t       lookup_vaddr,
    output logic                hit,
    output tlb_pkg::ppn_t       phys,
    output tlb_pkg::accesstag_t accesstag,

    // write side
    input  tlb_pkg::vpn_t       wr_vaddr,
    input  tlb_pkg::ppn_t       wr_phys,
    input  tlb_pkg::accesstag_t wr_accesstag,

    // invalidate side
    input  tlb_pkg::set_index_t inv_index
);

    import tlb_pkg::*;

    localparam int ways = `TLB_WAYS;

    typedef logic [`TLB_WAYS_W-1:0] way_index_t;

    // round-robin replacement pointer
    way_index_t victim_way;

    tlb_cmd_t   way_command   [ways];
    logic [ways-1:0] way_hit;
    ppn_t       way_phys      [ways];
    accesstag_t way_accesstag [ways];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            victim_way <= '0;
        end else if (command == `TLB_CMD_WRITE) begin
            victim_way <= victim_way + 1'b1;
        end
    end

    for (genvar g = 0; g < ways; g++) begin : gen_way
        // writes land in the victim way only
        assign way_command[g] =
            (command == `TLB_CMD_WRITE && victim_way != way_index_t'(g))
            ? `TLB_CMD_NONE : command;

        tlb_way i_way (
            .clk          (clk),
            .rst_n        (rst_n),
            .command      (way_command[g]),
            .lookup_vaddr (lookup_vaddr),
            .hit          (way_hit[g]),
            .phys         (way_phys[g]),
            .accesstag    (way_accesstag[g]),
            .wr_vaddr     (wr_vaddr),
            .wr_phys      (wr_phys),
            .wr_accesstag (wr_accesstag),
            .inv_index    (inv_index)
        );
    end

    // way 0 on a miss, otherwise the highest hitting way
    always_comb begin
        hit       = way_hit[0];
        phys      = way_phys[0];
        accesstag = way_accesstag[0];
        for (int w = 1; w < ways; w++) begin
            if (way_hit[w]) begin
                hit       = 1'b1;
                phys      = way_phys[w];
                accesstag = way_accesstag[w];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/tlb_arbiter.sv
`default_nettype none

`include "tlb_macros.svh"

module tlb_arbiter (
    input  logic              clk,
    input  logic              rst_n,

    // fetch client
    input  logic              if_req,
    input  tlb_pkg::vpn_t     if_vaddr,
    output logic              if_grant,
    output logic              if_resp,

    // data client
    input  logic              dm_req,
    input  tlb_pkg::vpn_t     dm_vaddr,
    output logic              dm_grant,
    output logic              dm_resp,

    // maintenance strobes
    input  logic              wr,
    input  logic              inv,

    output tlb_pkg::tlb_cmd_t tlb_cmd,
    output tlb_pkg::vpn_t     lookup_vaddr
);

    import tlb_pkg::*;
    import arb_pkg::*;

    arb_state_t state;
    client_t    inflight_client;
    logic       pending;
    logic       maint;

    // maintenance takes the port and both clients wait
    assign maint = wr || inv;

    assign if_grant = !maint && if_req && (!dm_req || state == prefer_fetch);
    assign dm_grant = !maint && dm_req && (!if_req || state == prefer_data);

    assign lookup_vaddr = dm_grant ? dm_vaddr : if_vaddr;

    always_comb begin
        if (wr) begin
            tlb_cmd = `TLB_CMD_WRITE;
        end else if (inv) begin
            tlb_cmd = `TLB_CMD_INVALIDATE;
        end else if (if_grant || dm_grant) begin
            tlb_cmd = `TLB_CMD_RESOLVE;
        end else begin
            tlb_cmd = `TLB_CMD_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= prefer_fetch;
            pending <= 1'b0;
        end else begin
            pending <= if_grant || dm_grant;
            // the client just served goes to the back
            if (if_grant) begin
                state <= prefer_data;
            end else if (dm_grant) begin
                state <= prefer_fetch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (if_grant || dm_grant) begin
            inflight_client <= dm_grant ? client_data : client_fetch;
        end
    end

    // answer goes back to whoever issued the lookup
    assign if_resp = pending && (inflight_client == client_fetch);
    assign dm_resp = pending && (inflight_client == client_data);

endmodule

`default_nettype wire

//--- hdl/shared_tlb.sv
`default_nettype none

module shared_tlb (
    input  logic                clk,
    input  logic                rst_n,

    // fetch client
    input  logic                if_req,
    input  tlb_pkg::vpn_t       if_vaddr,
    output logic                if_grant,
    output logic                if_resp,

    // data client
    input  logic                dm_req,
    input  tlb_pkg::vpn_t       dm_vaddr,
    output logic                dm_grant,
    output logic                dm_resp,

    // entry write
    input  logic                wr,
    input  tlb_pkg::vpn_t       wr_vaddr,
    input  tlb_pkg::ppn_t       wr_phys,
    input  tlb_pkg::accesstag_t wr_accesstag,

    // set invalidate
    input  logic                inv,
    input  tlb_pkg::set_index_t inv_index,

    // result shared by both clients
    output logic                hit,
    output tlb_pkg::ppn_t       phys,
    output tlb_pkg::accesstag_t accesstag
);

    import tlb_pkg::*;

    tlb_cmd_t tlb_cmd;
    vpn_t     lookup_vaddr;

    tlb_arbiter i_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),

        .if_req       (if_req),
        .if_vaddr     (if_vaddr),
        .if_grant     (if_grant),
        .if_resp      (if_resp),

        .dm_req       (dm_req),
        .dm_vaddr     (dm_vaddr),
        .dm_grant     (dm_grant),
        .dm_resp      (dm_resp),

        .wr           (wr),
        .inv          (inv),

        .tlb_cmd      (tlb_cmd),
        .lookup_vaddr (lookup_vaddr)
    );

    // write and invalidate data bypass the arbiter
    tlb i_tlb (
        .clk          (clk),
        .rst_n        (rst_n),

        .command      (tlb_cmd),

        .lookup_vaddr (lookup_vaddr),
        .hit          (hit),
        .phys         (phys),
        .accesstag    (accesstag),

        .wr_vaddr     (wr_vaddr),
        .wr_phys      (wr_phys),
        .wr_accesstag (wr_accesstag),

        .inv_index    (inv_index)
    );

endmodule

`default_nettype wire

//--- verif/shared_tlb_tb.sv
`default_nettype none

`include "tlb_macros.svh"

module shared_tlb_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import tlb_pkg::*;

    localparam int ways = `TLB_WAYS;
    localparam int sets = 1 << `TLB_ENTRIES_W;
    localparam int vtag_w = $bits(vpn_t) - `TLB_ENTRIES_W;

    logic       clk;
    logic       rst_n;
    logic       if_req;
    vpn_t       if_vaddr;
    logic       if_grant;
    logic       if_resp;
    logic       dm_req;
    vpn_t       dm_vaddr;
    logic       dm_grant;
    logic       dm_resp;
    logic       wr;
    vpn_t       wr_vaddr;
    ppn_t       wr_phys;
    accesstag_t wr_accesstag;
    logic       inv;
    set_index_t inv_index;
    logic       hit;
    ppn_t       phys;
    accesstag_t accesstag;

    // reference model of the TLB contents
    logic [vtag_w-1:0] m_vtag  [ways][sets];
    ppn_t              m_phys  [ways][sets];
    accesstag_t        m_tag   [ways][sets];
    logic              m_valid [ways][sets];
    int                m_victim;

    logic [31:0] seed;
    vpn_t        repl_addr [5];

    shared_tlb i_shared_tlb (
        .clk          (clk),
        .rst_n        (rst_n),
        .if_req       (if_req),
        .if_vaddr     (if_vaddr),
        .if_grant     (if_grant),
        .if_resp      (if_resp),
        .dm_req       (dm_req),
        .dm_vaddr     (dm_vaddr),
        .dm_grant     (dm_grant),
        .dm_resp      (dm_resp),
        .wr           (wr),
        .wr_vaddr     (wr_vaddr),
        .wr_phys      (wr_phys),
        .wr_accesstag (wr_accesstag),
        .inv          (inv),
        .inv_index    (inv_index),
        .hit          (hit),
        .phys         (phys),
        .accesstag    (accesstag)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // upper LCG bits are the better ones
    function automatic vpn_t random_vaddr();
        logic [31:0] r;
        r = next_random();
        return r[31:12];
    endfunction

    function automatic vpn_t random_vaddr_in_set(input set_index_t s);
        vpn_t v;
        v = random_vaddr();
        v[`TLB_ENTRIES_W-1:0] = s;
        return v;
    endfunction

    function automatic ppn_t random_phys();
        logic [31:0] r;
        r = next_random();
        return r[31:10];
    endfunction

    function automatic accesstag_t random_valid_tag();
        logic [31:0] r;
        r = next_random();
        return r[31:24] | 8'h01;
    endfunction

    function automatic void model_write(input vpn_t va, input ppn_t pa, input accesstag_t at);
        set_index_t s;
        s = va[`TLB_ENTRIES_W-1:0];
        m_vtag[m_victim][s]  = va[$bits(vpn_t)-1:`TLB_ENTRIES_W];
        m_phys[m_victim][s]  = pa;
        m_tag[m_victim][s]   = at;
        m_valid[m_victim][s] = at[`TLB_VALID_BIT];
        m_victim = (m_victim + 1) % ways;
    endfunction

    function automatic void model_invalidate(input set_index_t s);
        for (int w = 0; w < ways; w++) begin
            m_tag[w][s]   = '0;
            m_valid[w][s] = 1'b0;
        end
    endfunction

    // highest matching way wins
    function automatic void model_lookup(input vpn_t va, output logic h, output ppn_t p,
                                         output accesstag_t t);
        set_index_t s;
        s = va[`TLB_ENTRIES_W-1:0];
        h = 1'b0;
        p = '0;
        t = '0;
        for (int w = 0; w < ways; w++) begin
            if (m_valid[w][s] && m_vtag[w][s] == va[$bits(vpn_t)-1:`TLB_ENTRIES_W]) begin
                h = 1'b1;
                p = m_phys[w][s];
                t = m_tag[w][s];
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out after 20 cycles waiting for %s", what);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        m_victim = 0;
    endtask

    task automatic write_entry(input vpn_t va, input ppn_t pa, input accesstag_t at);
        @(posedge clk);
        #1;
        wr = 1'b1;
        wr_vaddr = va;
        wr_phys = pa;
        wr_accesstag = at;
        model_write(va, pa, at);
        @(posedge clk);
        #1;
        wr = 1'b0;
    endtask

    task automatic invalidate_set(input set_index_t s);
        @(posedge clk);
        #1;
        inv = 1'b1;
        inv_index = s;
        model_invalidate(s);
        @(posedge clk);
        #1;
        inv = 1'b0;
    endtask

    // client 0 is fetch, 1 is data
    task automatic run_lookup(input logic client, input vpn_t va, output logic got_hit);
        int waited;
        logic exp_hit;
        ppn_t exp_phys;
        accesstag_t exp_tag;
        @(posedge clk);
        #1;
        if (client) begin
            dm_req = 1'b1;
            dm_vaddr = va;
        end else begin
            if_req = 1'b1;
            if_vaddr = va;
        end
        waited = 0;
        @(negedge clk);
        while (!(client ? dm_grant : if_grant)) begin
            waited++;
            if (waited >= 20) report_timeout("grant");
            @(negedge clk);
        end
        model_lookup(va, exp_hit, exp_phys, exp_tag);
        @(posedge clk);
        #1;
        if_req = 1'b0;
        dm_req = 1'b0;
        waited = 1;
        @(negedge clk);
        while (!(client ? dm_resp : if_resp)) begin
            waited++;
            if (waited > 20) report_timeout("response");
            @(negedge clk);
        end
        check_value("resp latency", waited, 1);
        check_value(client ? "if_resp" : "dm_resp", client ? if_resp : dm_resp, 1'b0);
        check_value("hit", hit, exp_hit);
        if (exp_hit) begin
            check_value("phys", phys, exp_phys);
            check_value("accesstag", accesstag, exp_tag);
        end
        got_hit = hit;
    endtask

    task automatic lookup_fetch(input vpn_t va, output logic got_hit);
        run_lookup(1'b0, va, got_hit);
    endtask

    task automatic lookup_data(input vpn_t va, output logic got_hit);
        run_lookup(1'b1, va, got_hit);
    endtask

    task automatic test_miss_after_flush();
        logic got;
        for (int i = 0; i < 8; i++) begin
            lookup_fetch(random_vaddr(), got);
            check_value("hit after flush", got, 1'b0);
            lookup_data(random_vaddr(), got);
            check_value("hit after flush", got, 1'b0);
        end
    endtask

    task automatic test_write_and_hit();
        vpn_t va;
        ppn_t pa;
        accesstag_t at;
        logic got;
        va = random_vaddr();
        pa = random_phys();
        at = random_valid_tag();
        write_entry(va, pa, at);
        lookup_fetch(va, got);
        check_value("written entry hit", got, 1'b1);
        check_value("written phys", phys, pa);
        check_value("written accesstag", accesstag, at);
        // same set, one vtag bit flipped
        lookup_fetch(va ^ (vpn_t'(1) << `TLB_ENTRIES_W), got);
        check_value("other vtag hit", got, 1'b0);
    endtask

    task automatic test_replacement();
        vpn_t base;
        logic got;
        base = random_vaddr();
        for (int i = 0; i < 5; i++) begin
            repl_addr[i] = base + (vpn_t'(i) << `TLB_ENTRIES_W);
            write_entry(repl_addr[i], random_phys(), random_valid_tag());
        end
        // fifth write lands on the way of the first
        for (int i = 0; i < 5; i++) begin
            lookup_data(repl_addr[i], got);
            check_value("replacement hit", got, i != 0);
        end
    endtask

    task automatic test_invalidate();
        set_index_t s;
        vpn_t other;
        logic got;
        s = repl_addr[0][`TLB_ENTRIES_W-1:0];
        other = random_vaddr_in_set(s + 1'b1);
        write_entry(other, random_phys(), random_valid_tag());
        invalidate_set(s);
        for (int i = 0; i < 5; i++) begin
            lookup_fetch(repl_addr[i], got);
            check_value("hit in invalidated set", got, 1'b0);
        end
        lookup_data(other, got);
        check_value("hit in other set", got, 1'b1);
    endtask

    // both clients request every cycle, with maintenance strobes in between
    task automatic test_arbitration();
        vpn_t f_addr [8];
        vpn_t d_addr [8];
        vpn_t hit_addr [4];
        int f_idx;
        int d_idx;
        logic expect_data;
        logic prev_valid;
        logic prev_client;
        logic winner;
        logic exp_hit;
        ppn_t exp_phys;
        accesstag_t exp_tag;
        vpn_t va;
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            hit_addr[i] = random_vaddr_in_set(set_index_t'(5 + i / 2));
            write_entry(hit_addr[i], random_phys(), random_valid_tag());
        end
        for (int i = 0; i < 8; i++) begin
            f_addr[i] = (i % 2 == 0) ? hit_addr[(i / 2) % 2] : random_vaddr();
            d_addr[i] = (i % 2 == 0) ? hit_addr[2 + (i / 2) % 2] : random_vaddr();
        end
        f_idx = 0;
        d_idx = 0;
        expect_data = 1'b0;
        prev_valid = 1'b0;
        prev_client = 1'b0;
        for (int c = 0; c < 20; c++) begin
            @(posedge clk);
            #1;
            if_req = (f_idx < 8);
            dm_req = (d_idx < 8);
            if_vaddr = f_addr[f_idx % 8];
            dm_vaddr = d_addr[d_idx % 8];
            wr = (c == 3 || c == 10);
            inv = (c == 7);
            if (wr) begin
                wr_vaddr = random_vaddr_in_set(set_index_t'(12));
                wr_phys = random_phys();
                wr_accesstag = random_valid_tag();
                model_write(wr_vaddr, wr_phys, wr_accesstag);
            end
            if (inv) begin
                inv_index = set_index_t'(13);
                model_invalidate(inv_index);
            end
            @(negedge clk);
            check_value("if_resp", if_resp, prev_valid && !prev_client);
            check_value("dm_resp", dm_resp, prev_valid && prev_client);
            if (prev_valid) begin
                check_value("hit", hit, exp_hit);
                if (exp_hit) begin
                    check_value("phys", phys, exp_phys);
                    check_value("accesstag", accesstag, exp_tag);
                end
            end
            prev_valid = 1'b0;
            if (wr || inv || !(if_req || dm_req)) begin
                check_value("if_grant", if_grant, 1'b0);
                check_value("dm_grant", dm_grant, 1'b0);
            end else begin
                winner = dm_req && (!if_req || expect_data);
                check_value("if_grant", if_grant, !winner);
                check_value("dm_grant", dm_grant, winner);
                va = winner ? d_addr[d_idx] : f_addr[f_idx];
                model_lookup(va, exp_hit, exp_phys, exp_tag);
                prev_valid = 1'b1;
                prev_client = winner;
                expect_data = !winner;
                if (winner) d_idx++;
                else f_idx++;
            end
        end
        if_req = 1'b0;
        dm_req = 1'b0;
        wr = 1'b0;
        inv = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        if_req = 1'b0;
        if_vaddr = '0;
        dm_req = 1'b0;
        dm_vaddr = '0;
        wr = 1'b0;
        wr_vaddr = '0;
        wr_phys = '0;
        wr_accesstag = '0;
        inv = 1'b0;
        inv_index = '0;
        seed = 32'hfb95205d;
        m_victim = 0;

        apply_reset();
        // storage arrays come up unknown
        for (int s = 0; s < sets; s++) begin
            invalidate_set(set_index_t'(s));
        end

        test_miss_after_flush();
        test_write_and_hit();
        test_replacement();
        test_invalidate();
        test_arbitration();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- shared_tlb.f
+incdir+common
common/tlb_pkg.sv
common/arb_pkg.sv
tlb/mem_1w1r.sv
tlb/tlb_way.sv
tlb/tlb.sv
hdl/tlb_arbiter.sv
hdl/shared_tlb.sv
verif/shared_tlb_tb.sv

//--- Makefile
TOP = shared_tlb_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f shared_tlb.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
